//--- verilog/icache_pkg.sv
// ------------------------------
// Instruction cache package.
// Cache geometry, address field
// positions and refill states.
// ------------------------------

`default_nettype none

package icache_pkg;

    // ------------------------------
    // Geometry.
    // ------------------------------
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int BLOCK_COUNT = 16;
    localparam int WORD_COUNT  = 4;

    // Field widths, low to high.
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_OFF_W = 2;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

    // Lowest bit of each field.
    localparam int WORD_OFF_LSB = BYTE_OFF_W;
    localparam int INDEX_LSB    = WORD_OFF_LSB + WORD_OFF_W;
    localparam int TAG_LSB      = INDEX_LSB + INDEX_W;

    // ------------------------------
    // Refill controller states.
    // ------------------------------
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_WAIT,
        RF_REPLAY
    } refill_state_t;

endpackage

`default_nettype wire

//--- verilog/icache_lookup_if.sv
// ------------------------------
// Lookup stage bundle.
// One looked-up request passed
// from the lookup stage onward.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

interface icache_lookup_if
    import icache_pkg::*;
();

    // Strobe, one cycle per request.
    logic              valid;

    // Request address and stored word.
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] instr;

    // Tag matched a valid line.
    logic              hit;

    modport src (
        output valid,
        output addr,
        output instr,
        output hit
    );

    modport dst (
        input valid,
        input addr,
        input instr,
        input hit
    );

endinterface

`default_nettype wire

//--- verilog/instr_cache.sv
// ------------------------------
// Direct-mapped cache storage.
// Tags, valid bits and words.
// Combinational read port and a
// clocked fill write port.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module instr_cache
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Fill write port.
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_data,

    // Lookup read port.
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic [WORD_W-1:0] o_instr,
    output logic [TAG_W-1:0]  o_tag,
    output logic              o_valid
);

    // Address fields.
    logic [TAG_W-1:0]      wr_tag;
    logic [INDEX_W-1:0]    wr_index;
    logic [WORD_OFF_W-1:0] wr_off;
    logic [INDEX_W-1:0]    rd_index;
    logic [WORD_OFF_W-1:0] rd_off;

    // Storage arrays.
    logic [TAG_W-1:0]       tag_mem  [BLOCK_COUNT];
    logic [WORD_W-1:0]      word_mem [BLOCK_COUNT][WORD_COUNT];
    logic [BLOCK_COUNT-1:0] valid_mem;

    assign wr_tag   = i_addr[ADDR_W-1:TAG_LSB];
    assign wr_index = i_addr[TAG_LSB-1:INDEX_LSB];
    assign wr_off   = i_addr[INDEX_LSB-1:WORD_OFF_LSB];
    assign rd_index = i_rd_addr[TAG_LSB-1:INDEX_LSB];
    assign rd_off   = i_rd_addr[INDEX_LSB-1:WORD_OFF_LSB];

    // Valid bits, cleared on reset.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_mem <= '0;
        end else if (i_we) begin
            valid_mem[wr_index] <= 1'b1;
        end
    end

    // Tag and word arrays.
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[wr_index]          <= wr_tag;
            word_mem[wr_index][wr_off] <= i_data;
        end
    end

    assign o_tag   = tag_mem[rd_index];
    assign o_valid = valid_mem[rd_index];
    assign o_instr = word_mem[rd_index][rd_off];

endmodule

`default_nettype wire

//--- verilog/icache_lookup.sv
// ------------------------------
// Lookup pipeline stages.
// Stage 1 holds the request and
// reads the storage. Stage 2
// registers the tag compare.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module icache_lookup
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Fetch request.
    input  logic              i_req_valid,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic              i_busy,

    // Storage read port.
    output logic [ADDR_W-1:0] o_rd_addr,
    input  logic [WORD_W-1:0] i_instr,
    input  logic [TAG_W-1:0]  i_tag,
    input  logic              i_line_valid,

    // Next stage.
    icache_lookup_if.src      lk
);

    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic              tag_hit;

    // ------------------------------
    // Stage 1.
    // ------------------------------

    // Holds its request while a refill runs.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            s1_valid <= 1'b0;
        end else if (!i_busy) begin
            s1_valid <= i_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_busy && i_req_valid) begin
            s1_addr <= i_req_addr;
        end
    end

    // Storage is re-read every cycle.
    assign o_rd_addr = s1_addr;
    assign tag_hit   = i_line_valid && (i_tag == s1_addr[ADDR_W-1:TAG_LSB]);

    // ------------------------------
    // Stage 2.
    // ------------------------------

    // Bubble while busy.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            lk.valid <= 1'b0;
            lk.hit   <= 1'b0;
        end else begin
            lk.valid <= s1_valid & ~i_busy;
            lk.hit   <= tag_hit;
        end
    end

    always_ff @(posedge clk) begin
        lk.addr  <= s1_addr;
        lk.instr <= i_instr;
    end

endmodule

`default_nettype wire

//--- verilog/icache_refill.sv
// ------------------------------
// Miss refill controller.
// Reads a whole line word by
// word, fills the storage and
// replays the missed word.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Second stage result.
    icache_lookup_if.dst      lk,
    output logic              o_busy,

    // Instruction memory.
    output logic              o_mem_rd,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_valid,
    input  logic [WORD_W-1:0] i_mem_data,

    // Storage fill port.
    output logic              o_fill_we,
    output logic [ADDR_W-1:0] o_fill_addr,
    output logic [WORD_W-1:0] o_fill_data,

    // Replay to response stage.
    output logic              o_replay_valid,
    output logic [WORD_W-1:0] o_replay_instr
);

    refill_state_t         state;
    refill_state_t         state_next;
    logic [ADDR_W-1:0]     miss_addr;
    logic [WORD_OFF_W-1:0] word_cnt;
    logic [WORD_W-1:0]     replay_word;
    logic                  miss_seen;
    logic                  last_word;
    logic                  word_ret;
    logic [ADDR_W-1:0]     word_addr;

    assign miss_seen = lk.valid & ~lk.hit;
    assign last_word = (word_cnt == WORD_OFF_W'(WORD_COUNT - 1));
    assign word_ret  = (state == RF_WAIT) & i_mem_valid;

    // Line base plus current word offset.
    assign word_addr = {miss_addr[ADDR_W-1:INDEX_LSB], word_cnt, {BYTE_OFF_W{1'b0}}};

    // ------------------------------
    // State machine.
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            RF_IDLE: begin
                if (miss_seen) begin
                    state_next = RF_REQ;
                end
            end
            RF_REQ: begin
                state_next = RF_WAIT;
            end
            RF_WAIT: begin
                if (i_mem_valid) begin
                    state_next = last_word ? RF_REPLAY : RF_REQ;
                end
            end
            RF_REPLAY: begin
                state_next = RF_IDLE;
            end
            default: begin
                state_next = RF_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state    <= RF_IDLE;
            word_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == RF_IDLE) begin
                word_cnt <= '0;
            end else if (word_ret) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // Miss address and the word to replay.
    always_ff @(posedge clk) begin
        if (state == RF_IDLE && miss_seen) begin
            miss_addr <= lk.addr;
        end
        if (word_ret && word_cnt == miss_addr[INDEX_LSB-1:WORD_OFF_LSB]) begin
            replay_word <= i_mem_data;
        end
    end

    // ------------------------------
    // Outputs.
    // ------------------------------
    assign o_busy         = (state != RF_IDLE) | miss_seen;
    assign o_mem_rd       = (state == RF_REQ);
    assign o_mem_addr     = word_addr;
    assign o_fill_we      = word_ret;
    assign o_fill_addr    = word_addr;
    assign o_fill_data    = i_mem_data;
    assign o_replay_valid = (state == RF_REPLAY);
    assign o_replay_instr = replay_word;

endmodule

`default_nettype wire

//--- verilog/icache_resp.sv
// ------------------------------
// Response stage.
// Registers a hit word or a
// replayed refill word.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module icache_resp
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Second stage result.
    icache_lookup_if.dst      lk,

    // Replay from refill.
    input  logic              i_replay_valid,
    input  logic [WORD_W-1:0] i_replay_instr,

    // Fetch response.
    output logic              o_resp_valid,
    output logic [WORD_W-1:0] o_resp_instr
);

    logic hit_valid;

    assign hit_valid = lk.valid & lk.hit;

    // Hit and replay are never seen together.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= hit_valid | i_replay_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid) begin
            o_resp_instr <= lk.instr;
        end else if (i_replay_valid) begin
            o_resp_instr <= i_replay_instr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
// ------------------------------
// Instruction cache top level.
// Lookup, refill and response
// stages around the storage.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Fetch request and response.
    input  logic              i_req_valid,
    input  logic [ADDR_W-1:0] i_req_addr,
    output logic              o_busy,
    output logic              o_resp_valid,
    output logic [WORD_W-1:0] o_resp_instr,

    // Instruction memory.
    output logic              o_mem_rd,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_valid,
    input  logic [WORD_W-1:0] i_mem_data
);

    // Storage read side.
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] cache_instr;
    logic [TAG_W-1:0]  cache_tag;
    logic              cache_valid;

    // Fill and replay paths.
    logic              fill_we;
    logic [ADDR_W-1:0] fill_addr;
    logic [WORD_W-1:0] fill_data;
    logic              replay_valid;
    logic [WORD_W-1:0] replay_instr;

    // Pipeline stall.
    logic              busy;

    icache_lookup_if lk ();

    instr_cache instr_cache_i (
        .clk       (clk),
        .arstn     (arstn),
        .i_we      (fill_we),
        .i_addr    (fill_addr),
        .i_data    (fill_data),
        .i_rd_addr (rd_addr),
        .o_instr   (cache_instr),
        .o_tag     (cache_tag),
        .o_valid   (cache_valid)
    );

    icache_lookup icache_lookup_i (
        .clk          (clk),
        .arstn        (arstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_busy       (busy),
        .o_rd_addr    (rd_addr),
        .i_instr      (cache_instr),
        .i_tag        (cache_tag),
        .i_line_valid (cache_valid),
        .lk           (lk.src)
    );

    icache_refill icache_refill_i (
        .clk            (clk),
        .arstn          (arstn),
        .lk             (lk.dst),
        .o_busy         (busy),
        .o_mem_rd       (o_mem_rd),
        .o_mem_addr     (o_mem_addr),
        .i_mem_valid    (i_mem_valid),
        .i_mem_data     (i_mem_data),
        .o_fill_we      (fill_we),
        .o_fill_addr    (fill_addr),
        .o_fill_data    (fill_data),
        .o_replay_valid (replay_valid),
        .o_replay_instr (replay_instr)
    );

    icache_resp icache_resp_i (
        .clk            (clk),
        .arstn          (arstn),
        .lk             (lk.dst),
        .i_replay_valid (replay_valid),
        .i_replay_instr (replay_instr),
        .o_resp_valid   (o_resp_valid),
        .o_resp_instr   (o_resp_instr)
    );

    assign o_busy = busy;

endmodule

`default_nettype wire

//--- verification/icache_tb.sv
// ------------------------------
// Instruction cache testbench.
// Memory model with random delay,
// a tag model and a response queue.
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    localparam int REQ_LIMIT   = 100;
    localparam int DRAIN_LIMIT = 400;
    localparam int RANDOM_REQS = 64;

    logic              clk;
    logic              arstn;
    logic              i_req_valid;
    logic [ADDR_W-1:0] i_req_addr;
    logic              o_busy;
    logic              o_resp_valid;
    logic [WORD_W-1:0] o_resp_instr;
    logic              o_mem_rd;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              i_mem_valid;
    logic [WORD_W-1:0] i_mem_data;

    // Expected traffic and the tag model.
    logic [ADDR_W-1:0]      exp_reads [$];
    logic [WORD_W-1:0]      exp_words [$];
    int                     exp_cycles [$];
    logic [TAG_W-1:0]       model_tag [BLOCK_COUNT];
    logic [BLOCK_COUNT-1:0] model_valid;
    logic                   prev_hit;

    logic [31:0] cycle_cnt;
    logic [31:0] lfsr_state     = 32'ha007;
    logic        timed_out      = 1'b0;
    int          value_errors   = 0;
    int          other_errors   = 0;
    int          mem_read_count = 0;
    int          exp_read_total = 0;

    icache_top icache_top_i (
        .clk          (clk),
        .arstn        (arstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp_instr (o_resp_instr),
        .o_mem_rd     (o_mem_rd),
        .o_mem_addr   (o_mem_addr),
        .i_mem_valid  (i_mem_valid),
        .i_mem_data   (i_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = '0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
    end

    // ------------------------------
    // Reference and helpers.
    // ------------------------------

    // Memory contents, a mix of the word address.
    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] a;
        logic [31:0] w;
        a = {addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
        w = a ^ 32'h5a3c96e1;
        return {w[18:0], w[31:19]} + a;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    task automatic stop_on_timeout(input string what);
        other_errors++;
        $display("Timed out while %s", what);
        timed_out = 1'b1;
        forever @(posedge clk);
    endtask

    // Ends the run once any wait has timed out.
    initial begin : timeout_watch
        wait (timed_out);
        print_counts();
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------
    // Model of accepted requests.
    // ------------------------------
    task automatic accept_request(input logic [ADDR_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic               hit;
        logic               timed;
        int                 i;
        idx = addr[TAG_LSB-1:INDEX_LSB];
        tag = addr[ADDR_W-1:TAG_LSB];
        hit = model_valid[idx] && (model_tag[idx] == tag);
        // Fixed latency only when nothing ahead can stall it.
        timed = hit && (prev_hit || exp_words.size() == 0);
        if (!hit) begin
            for (i = 0; i < WORD_COUNT; i++) begin
                exp_reads.push_back({addr[ADDR_W-1:INDEX_LSB], WORD_OFF_W'(i),
                                     {BYTE_OFF_W{1'b0}}});
            end
            exp_read_total  += WORD_COUNT;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        exp_words.push_back(mem_word(addr));
        exp_cycles.push_back(timed ? int'(cycle_cnt) + 3 : -1);
        prev_hit = hit;
    endtask

    task automatic compare_response();
        logic [WORD_W-1:0] want;
        int                want_cycle;
        if (exp_words.size() == 0) begin
            other_errors++;
            $display("Response in cycle %0d with no request outstanding", cycle_cnt);
        end else begin
            want       = exp_words.pop_front();
            want_cycle = exp_cycles.pop_front();
            check("o_resp_instr", o_resp_instr, want);
            if (want_cycle >= 0) begin
                check("response cycle", cycle_cnt, 32'(want_cycle));
            end
        end
    endtask

    task automatic log_mem_read();
        mem_read_count++;
        if (exp_reads.size() == 0) begin
            other_errors++;
            $display("Memory read of %h with no miss outstanding", o_mem_addr);
        end else begin
            check("o_mem_addr", o_mem_addr, exp_reads.pop_front());
        end
    endtask

    // Compare first, then accept, all mid-cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (!arstn) begin
                // Reads of an aborted refill never happen.
                exp_read_total -= exp_reads.size();
                model_valid = '0;
                prev_hit    = 1'b0;
                exp_reads.delete();
                exp_words.delete();
                exp_cycles.delete();
            end else begin
                if (o_resp_valid) compare_response();
                if (o_mem_rd) log_mem_read();
                if (i_req_valid && !o_busy) accept_request(i_req_addr);
            end
        end
    end

    // Memory answers each read after 0 to 3 cycles.
    initial begin : memory_model
        logic [ADDR_W-1:0] addr;
        logic [31:0]       delay;
        i_mem_valid = 1'b0;
        i_mem_data  = '0;
        forever begin
            @(negedge clk);
            if (arstn && o_mem_rd) begin
                addr = o_mem_addr;
                random_bits(2, delay);
                @(posedge clk);
                repeat (delay) @(posedge clk);
                #10;
                i_mem_valid = 1'b1;
                i_mem_data  = mem_word(addr);
                @(posedge clk);
                #10;
                i_mem_valid = 1'b0;
            end
        end
    end

    // ------------------------------
    // Stimulus tasks.
    // ------------------------------
    task automatic issue(input logic [ADDR_W-1:0] addr);
        int waited;
        waited      = 0;
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        @(negedge clk);
        while (o_busy && waited < REQ_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= REQ_LIMIT) begin
            stop_on_timeout("waiting for a request to be accepted");
        end
        @(posedge clk);
        #10;
    endtask

    task automatic idle_cycle();
        i_req_valid = 1'b0;
        @(posedge clk);
        #10;
    endtask

    task automatic wait_mem_read();
        int waited;
        waited = 0;
        while (!o_mem_rd && waited < REQ_LIMIT) begin
            waited++;
            @(posedge clk);
            #10;
        end
        if (waited >= REQ_LIMIT) begin
            stop_on_timeout("waiting for a refill to start");
        end
    endtask

    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        while ((exp_words.size() != 0 || exp_reads.size() != 0 || o_busy)
               && waited < DRAIN_LIMIT) begin
            waited++;
            @(posedge clk);
            #10;
        end
        if (waited >= DRAIN_LIMIT) begin
            stop_on_timeout({"draining the ", phase, " phase"});
        end else begin
            check("memory read count", 32'(mem_read_count), 32'(exp_read_total));
        end
    endtask

    task automatic apply_reset();
        int i;
        i_req_valid = 1'b0;
        arstn       = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check("o_busy", 32'(o_busy), 32'h0);
            check("o_resp_valid", 32'(o_resp_valid), 32'h0);
            check("o_mem_rd", 32'(o_mem_rd), 32'h0);
            @(posedge clk);
        end
        #10;
        arstn = 1'b1;
    endtask

    // ------------------------------
    // Test sequence.
    // ------------------------------
    initial begin : main_flow
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        int                reads_before;
        int                n;
        arstn       = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        addr        = '0;
        @(posedge clk);
        #10;
        apply_reset();

        // Cold miss on the third word of a line.
        reads_before = mem_read_count;
        issue(32'h0000_1048);
        idle_cycle();
        wait_drain("cold miss");
        check("cold miss reads", 32'(mem_read_count - reads_before), 32'(WORD_COUNT));

        // Back-to-back hits on the same line.
        reads_before = mem_read_count;
        issue(32'h0000_1040);
        issue(32'h0000_1044);
        issue(32'h0000_104c);
        issue(32'h0000_1048);
        idle_cycle();
        wait_drain("hit");
        check("hit reads", 32'(mem_read_count - reads_before), 32'h0);

        // Same index, other tag, then the evicted line again.
        reads_before = mem_read_count;
        issue(32'h0000_2048);
        issue(32'h0000_1044);
        idle_cycle();
        wait_drain("conflict");
        check("conflict reads", 32'(mem_read_count - reads_before), 32'(2 * WORD_COUNT));

        // Random addresses over four tags.
        for (n = 0; n < RANDOM_REQS; n++) begin
            random_bits(8, r);
            addr = {24'h000010 + {22'd0, r[7:6]}, r[5:2], r[1:0], {BYTE_OFF_W{1'b0}}};
            issue(addr);
            random_bits(2, r);
            if (r[1:0] == 2'b00) idle_cycle();
        end
        idle_cycle();
        wait_drain("random");

        // Reset in the middle of a refill drops the cached line.
        issue(32'h0000_8000);
        idle_cycle();
        wait_mem_read();
        apply_reset();
        reads_before = mem_read_count;
        issue(addr);
        idle_cycle();
        wait_drain("reset");
        check("reads after reset", 32'(mem_read_count - reads_before), 32'(WORD_COUNT));

        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/icache_pkg.sv
verilog/icache_lookup_if.sv
verilog/instr_cache.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_resp.sv
verilog/icache_top.sv
verification/icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = icache_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Testbench passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
